/* Bender.yml */
package:
  name: mlp_tile

sources:
  - verilog/mlp_pkg.sv
  - verilog/vector_fifo.sv
  - verilog/systolic_mmu.sv
  - verilog/activation_unit.sv
  - verilog/compute_engine.sv
  - verilog/mlp_tile.sv
  - target: test
    files:
      - testbench/tb_mlp_tile.sv

/* mlp_tile.f */
verilog/mlp_pkg.sv
verilog/vector_fifo.sv
verilog/systolic_mmu.sv
verilog/activation_unit.sv
verilog/compute_engine.sv
verilog/mlp_tile.sv
testbench/tb_mlp_tile.sv

/* testbench/tb_mlp_tile.sv */
`timescale 1ns/1ps

module tb_mlp_tile;
    import mlp_pkg::*;

    localparam int DEPTH = 4;

    typedef struct {
        act_t      x0;
        act_t      x1;
        act_func_t func;
        shift_t    sh;
        int        wset;
        bit        hold;
        out_vec_t  exp;
    } row_t;

    logic      clk;
    logic      reset;
    logic      wt_valid;
    logic      wt_row;
    logic      wt_col;
    act_t      wt_data;
    act_func_t act_func;
    shift_t    out_shift;
    logic      in_valid;
    logic      in_ready;
    in_vec_t   in_data;
    logic      out_valid;
    logic      out_ready;
    out_vec_t  out_data;
    logic      busy;

    // Weight sets indexed [set][row][col]
    // Set 0 matches the reset state
    act_t wsets [4][2][2] = '{'{'{0, 0}, '{0, 0}}, '{'{3, -2}, '{5, 7}},
                              '{'{-128, 127}, '{-128, 127}}, '{'{-4, 6}, '{1, -3}}};

    row_t     rows[$];
    out_vec_t expq[$];
    integer   seed;
    int       received;
    int       cur_wset;
    bit       hold_out;
    bit       saw_full;
    bit       table_ready;

    mlp_tile #(.DEPTH(DEPTH)) DUT (.*);

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_vec(input string name, input out_vec_t got, input out_vec_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic add_row(input int x0, input int x1, input act_func_t func, input int sh,
                           input int wset, input bit hold, input int y0, input int y1);
        row_t r;
        r.x0     = act_t'(x0);
        r.x1     = act_t'(x1);
        r.func   = func;
        r.sh     = shift_t'(sh);
        r.wset   = wset;
        r.hold   = hold;
        r.exp[0] = res_t'(y0);
        r.exp[1] = res_t'(y1);
        rows.push_back(r);
    endtask

    // y_j = x0*W[0][j] + x1*W[1][j], then ReLU, shift and int16 clamp
    task automatic build_table();
        add_row(5, -7, ACT_PASS, 0, 0, 0, 0, 0);
        add_row(1, 2, ACT_PASS, 0, 1, 0, 13, 12);
        add_row(-4, 3, ACT_PASS, 0, 1, 0, 3, 29);
        add_row(10, -10, ACT_PASS, 0, 1, 0, -20, -90);
        add_row(-128, 127, ACT_PASS, 0, 1, 0, 251, 1145);
        add_row(10, -10, ACT_RELU, 0, 1, 0, 0, 0);
        add_row(1, 2, ACT_RELU, 0, 1, 0, 13, 12);
        add_row(-4, 3, ACT_RELU, 0, 1, 0, 3, 29);
        add_row(-3, 1, ACT_RELU, 0, 1, 0, 0, 13);
        add_row(4, -1, ACT_RELU, 0, 1, 0, 7, 0);
        // Two int8 products reach 32768 at most and never drop below -32512
        add_row(-128, -128, ACT_PASS, 0, 2, 0, 32767, -32512);
        add_row(100, -50, ACT_PASS, 0, 2, 0, -6400, 6350);
        add_row(-128, -128, ACT_PASS, 4, 2, 0, 2048, -2032);
        add_row(3, 2, ACT_PASS, 4, 2, 0, -40, 39);
        add_row(-1, 0, ACT_PASS, 4, 2, 0, 8, -8);
        add_row(-128, -128, ACT_RELU, 8, 2, 0, 128, 0);
        add_row(10, 20, ACT_RELU, 8, 2, 0, 0, 14);
        // Burst larger than both buffers while the sink is held off
        add_row(0, 0, ACT_PASS, 0, 1, 1, 0, 0);
        add_row(1, 0, ACT_PASS, 0, 1, 1, 3, -2);
        add_row(0, 1, ACT_PASS, 0, 1, 1, 5, 7);
        add_row(1, 1, ACT_PASS, 0, 1, 1, 8, 5);
        add_row(2, -1, ACT_PASS, 0, 1, 1, 1, -11);
        add_row(-1, 2, ACT_PASS, 0, 1, 1, 7, 16);
        add_row(5, 5, ACT_PASS, 0, 1, 1, 40, 25);
        add_row(-5, 3, ACT_PASS, 0, 1, 1, 0, 31);
        add_row(7, -2, ACT_PASS, 0, 1, 1, 11, -28);
        add_row(-8, -8, ACT_PASS, 0, 1, 1, -64, -40);
        add_row(1, 2, ACT_PASS, 0, 3, 0, -2, 0);
        add_row(-4, 3, ACT_PASS, 0, 3, 0, 19, -33);
        add_row(10, -10, ACT_PASS, 0, 3, 0, -50, 90);
    endtask

    task automatic load_weights(input int set);
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 2; c++) begin
                wt_valid = 1'b1;
                wt_row   = r[0];
                wt_col   = c[0];
                wt_data  = wsets[set][r][c];
                @(negedge clk);
            end
        end
        wt_valid = 1'b0;
    endtask

    // in_ready only moves after a rising edge, so it is steady at the falling edge
    task automatic send_vec(input row_t r);
        in_valid = 1'b1;
        in_data  = {r.x1, r.x0};
        while (!in_ready) begin
            @(negedge clk);
        end
        expq.push_back(r.exp);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // Result sink with random stalls
    initial begin
        logic [31:0] rnd;
        logic        ready_now;
        out_vec_t    exp;
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            if (hold_out && !in_ready) begin
                saw_full = 1'b1;
                hold_out = 1'b0;
            end
            ready_now = !hold_out && (rnd[1:0] != 2'b00);
            out_ready = ready_now;
            if (out_valid && ready_now) begin
                if (expq.size() == 0) begin
                    stop_run("A result came out with no vector pending");
                end else begin
                    exp = expq.pop_front();
                    check_vec("out_data", out_data, exp);
                    received++;
                end
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat ((rows.size() + 2 * DEPTH) * 40) @(posedge clk);
        stop_run("Timeout: the run did not finish within the cycle limit");
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        wt_valid  = 1'b0;
        wt_row    = 1'b0;
        wt_col    = 1'b0;
        wt_data   = '0;
        act_func  = ACT_PASS;
        out_shift = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        seed      = 32'hac1ca3b0;
        received  = 0;
        cur_wset  = 0;
        hold_out  = 1'b0;
        saw_full  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        for (int i = 0; i < rows.size(); i++) begin
            if (i == 0 || rows[i].func != rows[i-1].func || rows[i].sh != rows[i-1].sh ||
                rows[i].wset != rows[i-1].wset || rows[i].hold != rows[i-1].hold) begin
                // A held sink is released before draining
                hold_out = 1'b0;
                drain();
                if (rows[i].wset != cur_wset) begin
                    load_weights(rows[i].wset);
                    cur_wset = rows[i].wset;
                end
                act_func  = rows[i].func;
                out_shift = rows[i].sh;
                hold_out  = rows[i].hold;
            end
            send_vec(rows[i]);
        end
        drain();
        check_bit("in_ready low under back-pressure", saw_full, 1'b1);
        if (received != rows.size() || expq.size() != 0) begin
            stop_run($sformatf("Only %0d of %0d results came out", received, rows.size()));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* verilog/activation_unit.sv */
`timescale 1ns/1ps

module activation_unit
    import mlp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  acc_t [1:0] col_sum,
    input  act_func_t  act_func,
    input  shift_t     out_shift,
    output logic       out_valid,
    output out_vec_t   out_data
);

    localparam acc_t RES_MAX = 32'sd32767;
    localparam acc_t RES_MIN = -32'sd32768;

    // Rectify, scale down, then clamp into int16
    function automatic res_t shape(input acc_t sum, input act_func_t func, input shift_t sh);
        acc_t rect;
        acc_t scaled;
        rect   = (func == ACT_RELU && sum < 0) ? '0 : sum;
        scaled = rect >>> sh;
        if (scaled > RES_MAX) begin
            return res_t'(RES_MAX);
        end else if (scaled < RES_MIN) begin
            return res_t'(RES_MIN);
        end
        return res_t'(scaled);
    endfunction

    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            out_data[c] <= shape(col_sum[c], act_func, out_shift);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

/* verilog/compute_engine.sv */
`timescale 1ns/1ps

module compute_engine
    import mlp_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       vec_valid,
    input  in_vec_t                    vec_data,
    output logic                       vec_ready,
    input  logic [$clog2(DEPTH+1)-1:0] out_count,
    output logic                       res_valid,
    output out_vec_t                   res_data,
    input  logic                       wt_valid,
    input  logic                       wt_row,
    input  logic                       wt_col,
    input  act_t                       wt_data,
    input  act_func_t                  act_func,
    input  shift_t                     out_shift,
    output logic                       busy
);

    logic                               issue;
    logic [$clog2(MMU_LATENCY+1)-1:0]   in_flight;
    acc_t [1:0]                         col_sum;
    logic                               sum_valid;

    // Only issue when the output buffer is sure to have room on arrival
    assign vec_ready = (int'(out_count) + int'(in_flight)) < DEPTH;
    assign issue     = vec_valid && vec_ready;
    assign busy      = (in_flight != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else if (issue && !res_valid) begin
            in_flight <= in_flight + 1'b1;
        end else if (!issue && res_valid) begin
            in_flight <= in_flight - 1'b1;
        end
    end

    systolic_mmu u_mmu (
        .clk       (clk),
        .reset     (reset),
        .wt_valid  (wt_valid),
        .wt_row    (wt_row),
        .wt_col    (wt_col),
        .wt_data   (wt_data),
        .issue     (issue),
        .vec_in    (vec_data),
        .col_sum   (col_sum),
        .sum_valid (sum_valid)
    );

    activation_unit u_act (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sum_valid),
        .col_sum   (col_sum),
        .act_func  (act_func),
        .out_shift (out_shift),
        .out_valid (res_valid),
        .out_data  (res_data)
    );

endmodule

/* verilog/mlp_pkg.sv */
package mlp_pkg;

    // Element widths
    localparam int ACT_W = 8;
    localparam int ACC_W = 32;
    localparam int RES_W = 16;

    // Cycles from an input-buffer pop to the output-buffer write
    localparam int MMU_LATENCY = 4;

    // int8 weight or input element
    typedef logic signed [ACT_W-1:0] act_t;

    // Column accumulation value
    typedef logic signed [ACC_W-1:0] acc_t;

    // Saturated result element
    typedef logic signed [RES_W-1:0] res_t;

    // Lane 0 sits in the low element
    typedef act_t [1:0] in_vec_t;
    typedef res_t [1:0] out_vec_t;

    typedef logic [3:0] shift_t;

    typedef enum logic {
        ACT_PASS = 1'b0,
        ACT_RELU = 1'b1
    } act_func_t;

endpackage

/* verilog/mlp_tile.sv */
`timescale 1ns/1ps

module mlp_tile
    import mlp_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,
    // Weight writes
    input  logic      wt_valid,
    input  logic      wt_row,
    input  logic      wt_col,
    input  act_t      wt_data,
    // Static configuration
    input  act_func_t act_func,
    input  shift_t    out_shift,
    // Input vector stream
    input  logic      in_valid,
    output logic      in_ready,
    input  in_vec_t   in_data,
    // Result stream
    output logic      out_valid,
    input  logic      out_ready,
    output out_vec_t  out_data,
    output logic      busy
);

    logic                        rd_valid;
    logic                        rd_ready;
    in_vec_t                     rd_data;
    logic [$clog2(DEPTH+1)-1:0]  in_count;
    logic                        wr_valid;
    out_vec_t                    wr_data;
    logic [$clog2(DEPTH+1)-1:0]  out_count;
    logic                        engine_busy;

    assign busy = (in_count != '0) || (out_count != '0) || engine_busy;

    vector_fifo #(.DEPTH(DEPTH), .payload_t(in_vec_t)) in_buf (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (in_valid),
        .wr_data  (in_data),
        .wr_ready (in_ready),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_ready (rd_ready),
        .count    (in_count)
    );

    compute_engine #(.DEPTH(DEPTH)) u_engine (
        .clk       (clk),
        .reset     (reset),
        .vec_valid (rd_valid),
        .vec_data  (rd_data),
        .vec_ready (rd_ready),
        .out_count (out_count),
        .res_valid (wr_valid),
        .res_data  (wr_data),
        .wt_valid  (wt_valid),
        .wt_row    (wt_row),
        .wt_col    (wt_col),
        .wt_data   (wt_data),
        .act_func  (act_func),
        .out_shift (out_shift),
        .busy      (engine_busy)
    );

    // Engine credit guarantees room, so wr_ready goes unused
    vector_fifo #(.DEPTH(DEPTH), .payload_t(out_vec_t)) out_buf (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_ready (),
        .rd_valid (out_valid),
        .rd_data  (out_data),
        .rd_ready (out_ready),
        .count    (out_count)
    );

endmodule

/* verilog/systolic_mmu.sv */
`timescale 1ns/1ps

module systolic_mmu
    import mlp_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wt_valid,
    input  logic       wt_row,
    input  logic       wt_col,
    input  act_t       wt_data,
    input  logic       issue,
    input  in_vec_t    vec_in,
    output acc_t [1:0] col_sum,
    output logic       sum_valid
);

    // Stationary weights, indexed [row][col]
    act_t weight [2][2];

    // Stage 1: row-0 products and the row-1 skew register
    acc_t [1:0] row0_prod;
    act_t       row1_skew;
    logic       s1_valid;

    // Stage 2: partial sums passing down plus row-1 products
    acc_t [1:0] pass_sum;
    acc_t [1:0] row1_prod;
    logic       s2_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 2; r++) begin
                for (int c = 0; c < 2; c++) begin
                    weight[r][c] <= '0;
                end
            end
        end else if (wt_valid) begin
            weight[wt_row][wt_col] <= wt_data;
        end
    end

    // Products and partial sums move one stage per clock
    always_ff @(posedge clk) begin
        for (int c = 0; c < 2; c++) begin
            row0_prod[c] <= vec_in[0] * weight[0][c];
            pass_sum[c]  <= row0_prod[c];
            row1_prod[c] <= row1_skew * weight[1][c];
            col_sum[c]   <= pass_sum[c] + row1_prod[c];
        end
        // Row-1 lane enters one cycle behind row 0
        if (issue) begin
            row1_skew <= vec_in[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            s1_valid  <= issue;
            s2_valid  <= s1_valid;
            sum_valid <= s2_valid;
        end
    end

endmodule

/* verilog/vector_fifo.sv */
`timescale 1ns/1ps

module vector_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [15:0]
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_valid,
    input  payload_t                     wr_data,
    output logic                         wr_ready,
    output logic                         rd_valid,
    output payload_t                     rd_data,
    input  logic                         rd_ready,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          push;
    logic          pop;

    // Pointer advance with wrap for any DEPTH
    function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A full buffer still takes a write when it is popped in the same cycle
    assign wr_ready = (count < DEPTH) || rd_ready;
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
